/* frame_ram.sv */
module frame_ram #(
    parameter int depth     = pyr_pkg::full_pixels,
    parameter int addr_bits = pyr_pkg::full_addr_bits
) (
    input  logic                         clk_100mhz,
    input  logic                         wr_en_i,
    input  logic [addr_bits-1:0]         wr_addr_i,
    input  logic [pyr_pkg::pix_bits-1:0] wr_data_i,
    input  logic [addr_bits-1:0]         rd_addr_i,
    output logic [pyr_pkg::pix_bits-1:0] rd_data_o
);

    logic [pyr_pkg::pix_bits-1:0] mem [depth];

    always_ff @(posedge clk_100mhz) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle from address to data
    always_ff @(posedge clk_100mhz) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* image_sender.sv */
module image_sender (
    input  logic                               clk_100mhz,
    input  logic                               sys_rst,
    input  logic                               dump_i,
    input  logic                               dump_level_i,
    input  logic                               pyramid_done_i,
    output logic [pyr_pkg::full_addr_bits-1:0] rd_addr_o,
    output logic                               rd_level_o,
    input  logic [pyr_pkg::pix_bits-1:0]       rd_data_i,
    output logic [pyr_pkg::pix_bits-1:0]       tx_data_o,
    output logic                               tx_valid_o,
    input  logic                               tx_ready_i,
    output logic                               busy_o
);

    logic [1:0] phase; // 0 read issued, 1 data back, 2 offer, 3 drain
    logic accept;
    logic last_addr;

    assign accept = dump_i && pyramid_done_i && !busy_o;

    assign last_addr = (rd_level_o == pyr_pkg::lvl_half) ?
                       (int'(rd_addr_o) == pyr_pkg::half_pixels - 1) :
                       (int'(rd_addr_o) == pyr_pkg::full_pixels - 1);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy_o     <= 1'b0;
            phase      <= '0;
            rd_addr_o  <= '0;
            rd_level_o <= pyr_pkg::lvl_full;
            tx_valid_o <= 1'b0;
        end else if (!busy_o) begin
            phase     <= 2'd0;
            rd_addr_o <= '0;
            if (accept) begin
                busy_o     <= 1'b1;
                rd_level_o <= dump_level_i;
            end
        end else begin
            case (phase)
                2'd0: phase <= 2'd1; // ram latency
                2'd1: begin
                    tx_valid_o <= 1'b1;
                    phase      <= 2'd2;
                end
                2'd2: begin
                    if (tx_ready_i) begin // byte taken
                        tx_valid_o <= 1'b0;
                        if (last_addr) begin
                            phase <= 2'd3;
                        end else begin
                            rd_addr_o <= rd_addr_o + 1'b1;
                            phase     <= 2'd0;
                        end
                    end
                end
                default: begin
                    // ready comes back once the stop bit is out
                    if (tx_ready_i) begin
                        busy_o <= 1'b0;
                    end
                end
            endcase
        end
    end

    // held on valid until the transmitter takes it
    always_ff @(posedge clk_100mhz) begin
        if (busy_o && phase == 2'd1) begin
            tx_data_o <= rd_data_i;
        end
    end

endmodule

/* pyr_pkg.sv */
package pyr_pkg;

    // image geometry, full level and the one decimated level
    localparam int img_w = 16;
    localparam int img_h = 16;
    localparam int half_w = img_w / 2;
    localparam int half_h = img_h / 2;

    localparam int full_pixels = img_w * img_h;   // 256
    localparam int half_pixels = half_w * half_h; // 64

    // greyscale pixels
    localparam int pix_bits = 8;

    localparam int full_addr_bits = $clog2(full_pixels);
    localparam int half_addr_bits = $clog2(half_pixels);

    localparam int clks_per_baud = 8; // very fast baud, keeps sims short

    // dump level select
    localparam logic lvl_full = 1'b0;
    localparam logic lvl_half = 1'b1;

endpackage

/* pyramid_down.sv */
module pyramid_down (
    input  logic                               clk_100mhz,
    input  logic                               sys_rst,
    input  logic                               start_i,
    output logic [pyr_pkg::full_addr_bits-1:0] rd_addr_o,
    input  logic [pyr_pkg::pix_bits-1:0]       rd_data_i,
    output logic                               wr_en_o,
    output logic [pyr_pkg::half_addr_bits-1:0] wr_addr_o,
    output logic [pyr_pkg::pix_bits-1:0]       wr_data_o,
    output logic                               done_o
);

    logic active;
    logic [2:0] phase; // 0..3 issue taps, 4 writes the mean
    logic [$clog2(pyr_pkg::half_w)-1:0] hx;
    logic [$clog2(pyr_pkg::half_h)-1:0] hy;
    logic [pyr_pkg::pix_bits+1:0] sum; // four pixels need two extra bits
    logic [pyr_pkg::pix_bits+1:0] sum_next;
    logic last_col;
    logic last_row;

    // full row = 2*hy + dy, full col = 2*hx + dx, dy/dx taken from the tap index
    assign rd_addr_o = {hy, phase[1], hx, phase[0]};

    // data back this cycle belongs to tap phase-1
    assign sum_next = sum + {2'b00, rd_data_i};

    assign last_col = int'(hx) == pyr_pkg::half_w - 1;
    assign last_row = int'(hy) == pyr_pkg::half_h - 1;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            active  <= 1'b0;
            phase   <= '0;
            hx      <= '0;
            hy      <= '0;
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
            if (!active) begin
                phase  <= '0;
                hx     <= '0;
                hy     <= '0;
                active <= start_i;
            end else if (phase == 3'd4) begin
                phase   <= '0;
                wr_en_o <= 1'b1;
                if (last_col) begin
                    hx <= '0;
                    if (last_row) begin
                        hy     <= '0;
                        active <= 1'b0;
                        done_o <= 1'b1; // goes out with the last write
                    end else begin
                        hy <= hy + 1'b1;
                    end
                end else begin
                    hx <= hx + 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // accumulator and write data
    always_ff @(posedge clk_100mhz) begin
        if (phase == 3'd1) begin
            sum <= {2'b00, rd_data_i}; // first tap restarts the sum
        end else begin
            sum <= sum_next;
        end
        if (phase == 3'd4) begin
            wr_data_o <= sum_next[pyr_pkg::pix_bits+1:2]; // truncated mean
            wr_addr_o <= {hy, hx};
        end
    end

endmodule

/* pyramid_top.f */
pyr_pkg.sv
uart_rx.sv
uart_tx.sv
frame_ram.sv
pyramid_down.sv
image_sender.sv
pyramid_top.sv
pyramid_top_sva.sv
pyramid_top_tb.sv

/* pyramid_top.sv */
module pyramid_top (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic uart_rxd_i,
    input  logic dump_i,
    input  logic dump_level_i,
    output logic uart_txd_o,
    output logic image_loaded_o,
    output logic pyramid_done_o,
    output logic busy_o
);

    logic [pyr_pkg::pix_bits-1:0] rx_data;
    logic rx_valid;

    logic [pyr_pkg::full_addr_bits-1:0] load_addr;
    logic load_en;
    logic start_pyr;

    logic [pyr_pkg::full_addr_bits-1:0] pd_rd_addr;
    logic [pyr_pkg::full_addr_bits-1:0] full_rd_addr;
    logic [pyr_pkg::pix_bits-1:0] full_rd_data;
    logic pd_wr_en;
    logic [pyr_pkg::half_addr_bits-1:0] pd_wr_addr;
    logic [pyr_pkg::pix_bits-1:0] pd_wr_data;
    logic pd_done;
    logic [pyr_pkg::pix_bits-1:0] half_rd_data;

    logic [pyr_pkg::full_addr_bits-1:0] snd_addr;
    logic snd_level;
    logic [pyr_pkg::pix_bits-1:0] snd_data;

    logic [pyr_pkg::pix_bits-1:0] tx_data;
    logic tx_valid;
    logic tx_ready;

    uart_rx u_rx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rxd_i      (uart_rxd_i),
        .data_o     (rx_data),
        .valid_o    (rx_valid)
    );

    // image loader, bytes after the last pixel are dropped
    assign load_en = rx_valid && !image_loaded_o;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            load_addr      <= '0;
            image_loaded_o <= 1'b0;
            start_pyr      <= 1'b0;
            pyramid_done_o <= 1'b0;
        end else begin
            start_pyr <= 1'b0;
            if (load_en) begin
                load_addr <= load_addr + 1'b1;
                if (int'(load_addr) == pyr_pkg::full_pixels - 1) begin
                    image_loaded_o <= 1'b1;
                    start_pyr      <= 1'b1; // cycle after the last write
                end
            end
            if (pd_done) begin
                pyramid_done_o <= 1'b1;
            end
        end
    end

    // port b belongs to the decimator until the half level is built
    assign full_rd_addr = pyramid_done_o ? snd_addr : pd_rd_addr;
    assign snd_data = (snd_level == pyr_pkg::lvl_half) ? half_rd_data : full_rd_data;

    frame_ram #(
        .depth     (pyr_pkg::full_pixels),
        .addr_bits (pyr_pkg::full_addr_bits)
    ) u_full_ram (
        .clk_100mhz (clk_100mhz),
        .wr_en_i    (load_en),
        .wr_addr_i  (load_addr),
        .wr_data_i  (rx_data),
        .rd_addr_i  (full_rd_addr),
        .rd_data_o  (full_rd_data)
    );

    pyramid_down u_pyr_down (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .start_i    (start_pyr),
        .rd_addr_o  (pd_rd_addr),
        .rd_data_i  (full_rd_data),
        .wr_en_o    (pd_wr_en),
        .wr_addr_o  (pd_wr_addr),
        .wr_data_o  (pd_wr_data),
        .done_o     (pd_done)
    );

    frame_ram #(
        .depth     (pyr_pkg::half_pixels),
        .addr_bits (pyr_pkg::half_addr_bits)
    ) u_half_ram (
        .clk_100mhz (clk_100mhz),
        .wr_en_i    (pd_wr_en),
        .wr_addr_i  (pd_wr_addr),
        .wr_data_i  (pd_wr_data),
        .rd_addr_i  (snd_addr[pyr_pkg::half_addr_bits-1:0]),
        .rd_data_o  (half_rd_data)
    );

    image_sender u_sender (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .dump_i         (dump_i),
        .dump_level_i   (dump_level_i),
        .pyramid_done_i (pyramid_done_o),
        .rd_addr_o      (snd_addr),
        .rd_level_o     (snd_level),
        .rd_data_i      (snd_data),
        .tx_data_o      (tx_data),
        .tx_valid_o     (tx_valid),
        .tx_ready_i     (tx_ready),
        .busy_o         (busy_o)
    );

    uart_tx u_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .data_i     (tx_data),
        .valid_i    (tx_valid),
        .ready_o    (tx_ready),
        .txd_o      (uart_txd_o)
    );

endmodule

/* pyramid_top_sva.sv */
module pyramid_top_sva (
    input logic                         clk_100mhz,
    input logic                         sys_rst,
    input logic [pyr_pkg::pix_bits-1:0] tx_data_i,
    input logic                         tx_valid_i,
    input logic                         tx_ready_i,
    input logic                         busy_i,
    input logic                         pyramid_done_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // offered byte waits unchanged for the transmitter
    a_tx_hold: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i))
        else $error("tx_valid dropped or tx_data changed before tx_ready");

    // from reset until the half level exists no dump may run
    a_busy_reset: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        !pyramid_done_i |-> !busy_i)
        else $error("busy_o high after reset before pyramid_done_o");

    // sticky until the next reset
    a_done_sticky: assert property (@(posedge clk_100mhz)
        pyramid_done_i && !sys_rst |=> pyramid_done_i)
        else $error("pyramid_done_o fell without reset");

endmodule

bind pyramid_top pyramid_top_sva u_sva (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .tx_data_i      (tx_data),
    .tx_valid_i     (tx_valid),
    .tx_ready_i     (tx_ready),
    .busy_i         (busy_o),
    .pyramid_done_i (pyramid_done_o)
);

/* pyramid_top_tb.sv */
module pyramid_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] lfsr_seed = 32'h4253_8369;
    localparam int start_timeout = 500;  // cycles until a start bit shows up
    localparam int flag_timeout = 3000;
    localparam int idle_window = 2000;

    typedef struct packed {
        logic level;
        logic extra;      // stray bytes sent to the loader first
        logic busy_pulse; // second request while the dump runs
    } req_t;

    localparam req_t req_table [5] = '{
        '{pyr_pkg::lvl_full, 1'b0, 1'b0},
        '{pyr_pkg::lvl_half, 1'b0, 1'b0},
        '{pyr_pkg::lvl_full, 1'b1, 1'b0},
        '{pyr_pkg::lvl_half, 1'b0, 1'b1},
        '{pyr_pkg::lvl_full, 1'b0, 1'b1}
    };

    logic clk_100mhz = 1'b0;
    logic sys_rst;
    logic uart_rxd_i;
    logic dump_i;
    logic dump_level_i;
    logic uart_txd_o;
    logic image_loaded_o;
    logic pyramid_done_o;
    logic busy_o;

    logic [31:0] lfsr;
    logic [pyr_pkg::pix_bits-1:0] img_model [pyr_pkg::full_pixels];
    logic [pyr_pkg::pix_bits-1:0] half_model [pyr_pkg::half_pixels];
    logic [pyr_pkg::pix_bits-1:0] got_bytes [$];

    always #5 clk_100mhz = ~clk_100mhz;

    pyramid_top u_dut (.*);

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic flag_value(input int which);
        case (which)
            0: return image_loaded_o;
            1: return pyramid_done_o;
            default: return busy_o;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pixel(input logic [pyr_pkg::pix_bits-1:0] got,
                               input logic [pyr_pkg::pix_bits-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %02h, expected %02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic wait_flag(input int which, input logic value, input string name);
        int n;
        n = 0;
        while (flag_value(which) !== value) begin
            if (n == flag_timeout) begin
                abort_run($sformatf("timeout: %s never became %b", name, value));
            end else begin
                @(negedge clk_100mhz);
                n++;
            end
        end
    endtask

    task automatic next_pixel(output logic [pyr_pkg::pix_bits-1:0] p);
        p = '0;
        for (int i = 0; i < pyr_pkg::pix_bits; i++) begin
            p = {p[pyr_pkg::pix_bits-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr); // one step per bit
        end
    endtask

    task automatic send_serial(input logic [pyr_pkg::pix_bits-1:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_100mhz);
            #1 uart_rxd_i = frame[i];
            repeat (pyr_pkg::clks_per_baud - 1) @(posedge clk_100mhz);
        end
    endtask

    task automatic receive_byte(output logic [pyr_pkg::pix_bits-1:0] b);
        int n;
        n = 0;
        while (uart_txd_o !== 1'b0) begin
            if (n == start_timeout) begin
                abort_run("timeout: no start bit on the transmit line");
            end else begin
                @(negedge clk_100mhz);
                n++;
            end
        end
        repeat (pyr_pkg::clks_per_baud / 2) @(negedge clk_100mhz); // middle of start bit
        check_flag(uart_txd_o, 1'b0, "start bit");
        for (int i = 0; i < pyr_pkg::pix_bits; i++) begin
            repeat (pyr_pkg::clks_per_baud) @(negedge clk_100mhz);
            b[i] = uart_txd_o;
        end
        repeat (pyr_pkg::clks_per_baud) @(negedge clk_100mhz);
        check_flag(uart_txd_o, 1'b1, "stop bit");
    endtask

    task automatic collect_bytes(input int count);
        logic [pyr_pkg::pix_bits-1:0] b;
        got_bytes.delete();
        repeat (count) begin
            receive_byte(b);
            got_bytes.push_back(b);
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_100mhz);
            check_flag(uart_txd_o, 1'b1, "idle transmit line");
        end
    endtask

    task automatic request_dump(input logic level);
        @(posedge clk_100mhz);
        #1 dump_i = 1'b1;
        dump_level_i = level;
        @(posedge clk_100mhz);
        #1 dump_i = 1'b0;
    endtask

    initial begin
        logic [pyr_pkg::pix_bits-1:0] p;
        logic [pyr_pkg::pix_bits+1:0] s;
        int n_exp;
        sys_rst = 1'b1;
        uart_rxd_i = 1'b1;
        dump_i = 1'b0;
        dump_level_i = pyr_pkg::lvl_full;
        lfsr = lfsr_seed;
        repeat (10) @(posedge clk_100mhz);
        #1 sys_rst = 1'b0;
        @(negedge clk_100mhz);
        check_flag(uart_txd_o, 1'b1, "uart_txd_o after reset");
        check_flag(image_loaded_o, 1'b0, "image_loaded_o after reset");
        check_flag(pyramid_done_o, 1'b0, "pyramid_done_o after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");

        request_dump(pyr_pkg::lvl_full); // nothing loaded yet
        expect_idle(idle_window);
        check_flag(busy_o, 1'b0, "busy_o after early request");

        for (int i = 0; i < pyr_pkg::full_pixels; i++) begin
            next_pixel(p);
            img_model[i] = p;
            send_serial(p);
        end
        wait_flag(0, 1'b1, "image_loaded_o");
        wait_flag(1, 1'b1, "pyramid_done_o");

        // truncated mean of each 2x2 block
        for (int y = 0; y < pyr_pkg::half_h; y++) begin
            for (int x = 0; x < pyr_pkg::half_w; x++) begin
                s = {2'b00, img_model[(2*y)*pyr_pkg::img_w + 2*x]}
                  + {2'b00, img_model[(2*y)*pyr_pkg::img_w + 2*x + 1]}
                  + {2'b00, img_model[(2*y+1)*pyr_pkg::img_w + 2*x]}
                  + {2'b00, img_model[(2*y+1)*pyr_pkg::img_w + 2*x + 1]};
                half_model[y*pyr_pkg::half_w + x] = s[pyr_pkg::pix_bits+1:2];
            end
        end

        for (int t = 0; t < 5; t++) begin
            if (req_table[t].extra) begin
                repeat (4) begin
                    next_pixel(p);
                    send_serial(p); // loader is full, byte is dropped
                end
            end
            n_exp = (req_table[t].level == pyr_pkg::lvl_half) ?
                    pyr_pkg::half_pixels : pyr_pkg::full_pixels;
            request_dump(req_table[t].level);
            fork
                collect_bytes(n_exp);
                if (req_table[t].busy_pulse) begin
                    repeat (300) @(negedge clk_100mhz);
                    check_flag(busy_o, 1'b1, "busy_o during dump");
                    request_dump(~req_table[t].level);
                end
            join
            for (int i = 0; i < n_exp; i++) begin
                check_pixel(got_bytes[i],
                            (req_table[t].level == pyr_pkg::lvl_half) ? half_model[i] : img_model[i],
                            $sformatf("request %0d byte %0d", t, i));
            end
            wait_flag(2, 1'b0, "busy_o");
            expect_idle(200); // no second image follows
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pyramid_top_tb -f pyramid_top.f \
    --Mdir obj_dir -o pyramid_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/pyramid_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* uart_rx.sv */
module uart_rx (
    input  logic                         clk_100mhz,
    input  logic                         sys_rst,
    input  logic                         rxd_i,
    output logic [pyr_pkg::pix_bits-1:0] data_o,
    output logic                         valid_o
);

    logic rxd_meta;
    logic rxd_sync;
    logic busy;
    logic [$clog2(pyr_pkg::clks_per_baud)-1:0] baud_cnt;
    logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
    logic [pyr_pkg::pix_bits-1:0] shreg;
    logic bit_done;

    // start bit only waits half a period so later samples land mid-bit
    assign bit_done = (bit_idx == 4'd0) ?
                      (int'(baud_cnt) == pyr_pkg::clks_per_baud / 2 - 1) :
                      (int'(baud_cnt) == pyr_pkg::clks_per_baud - 1);

    assign data_o = shreg; // stable until the next data bit

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid_o  <= 1'b0;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            valid_o  <= 1'b0;
            if (!busy) begin
                baud_cnt <= '0;
                bit_idx  <= '0;
                busy     <= !rxd_sync; // falling edge = start
            end else if (bit_done) begin
                baud_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    busy <= !rxd_sync; // glitch, not a real start bit
                end else if (bit_idx == 4'd9) begin
                    busy    <= 1'b0;
                    valid_o <= rxd_sync; // framing error drops the byte
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk_100mhz) begin
        if (busy && bit_done && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shreg <= {rxd_sync, shreg[pyr_pkg::pix_bits-1:1]};
        end
    end

endmodule

/* uart_tx.sv */
module uart_tx (
    input  logic                         clk_100mhz,
    input  logic                         sys_rst,
    input  logic [pyr_pkg::pix_bits-1:0] data_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    output logic                         txd_o
);

    logic busy;
    logic [$clog2(pyr_pkg::clks_per_baud)-1:0] baud_cnt;
    logic [3:0] bit_idx;               // 0 start, 1..8 data, 9 stop
    logic [pyr_pkg::pix_bits:0] shreg; // data with the stop bit on top
    logic bit_done;

    assign ready_o  = !busy;
    assign bit_done = int'(baud_cnt) == pyr_pkg::clks_per_baud - 1;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd_o    <= 1'b1; // line idles high
        end else if (!busy) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            if (valid_i) begin
                busy  <= 1'b1;
                txd_o <= 1'b0; // start bit
            end
        end else if (bit_done) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0; // stop bit finished
            end else begin
                txd_o <= shreg[0];
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!busy && valid_i) begin
            shreg <= {1'b1, data_i};
        end else if (busy && bit_done) begin
            shreg <= {1'b1, shreg[pyr_pkg::pix_bits:1]};
        end
    end

endmodule
